// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= controlUnitTb
FILELIST ?= build.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
CASES ?= sim/instrCases.txt
VFLAGS ?= --binary --timing --timescale 1ns/1ps

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM_BIN) $(CASES)
	-./$(SIM_BIN) | tee $(LOG)
	@grep -q "TB PASSED" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== build.f ====
hdl/ctrlPkg.sv
hdl/instrDecoder.sv
hdl/stepSequencer.sv
hdl/controlEncoder.sv
hdl/controlUnit.sv
sim/controlUnitTb.sv

// ==== hdl/controlEncoder.sv ====
module controlEncoder import ctrlPkg::*; #(
  parameter int MemLatency = 1
) (
  input logic clk,
  input logic reset_in,
  input phase_t phase,
  input step_t step,
  input instrClass_t instrClass,
  input aluOp_t aluFunc,
  input opcode_t opcode,
  input funct_t funct,
  output logic pcWrite,
  output logic irWrite,
  output logic aluOutWrite,
  output logic regWrite,
  output logic regAWrite,
  output logic regBWrite,
  output pcSrc_t pcSrc,
  output aluSrcA_t aluSrcA,
  output aluSrcB_t aluSrcB,
  output regDst_t regDst,
  output regData_t regData,
  output aluOp_t aluOp
);

  localparam step_t LastFetch = step_t'(MemLatency + 1);

  logic jumpOp;
  logic moveOp;
  logic immShift;
  step_t writeStep;

  assign jumpOp = (opcode == opJ) || (opcode == opJal);
  assign moveOp = (opcode == opRType) && ((funct == fnMfhi) || (funct == fnMflo));
  assign immShift = (instrClass == clsShiftImm);
  assign writeStep = (instrClass == clsShiftVar) ? 3'd3 : 3'd2;  // Register file write step

  always_ff @(posedge clk) begin
    // Everything drops back to idle unless a step asks for it
    pcWrite <= 1'b0;
    irWrite <= 1'b0;
    aluOutWrite <= 1'b0;
    regWrite <= 1'b0;
    regAWrite <= 1'b0;
    regBWrite <= 1'b0;
    pcSrc <= pcAluResult;
    aluSrcA <= srcAPc;
    aluSrcB <= srcBRegB;
    regDst <= dstRt;
    regData <= dataAluOut;
    aluOp <= aluPassA;
    if (!reset_in) begin
      case (phase)
        phaseFetch: begin
          if (step == '0) begin  // PC + 4 into aluOut, load IR
            irWrite <= 1'b1;
            aluOutWrite <= 1'b1;
            aluOp <= aluAdd;
            aluSrcA <= srcAPc;
            aluSrcB <= srcBFour;
            pcSrc <= pcAluResult;
          end else if (step == LastFetch) begin
            pcWrite <= 1'b1;
            pcSrc <= jumpOp ? pcJumpTarget : pcAluOut;
            if (opcode == opJal) begin
              regWrite <= 1'b1;
              regDst <= dstRa;
              regData <= dataPc;
            end else if (moveOp) begin
              regWrite <= 1'b1;
              regDst <= dstRd;
              regData <= (funct == fnMfhi) ? dataHi : dataLo;
            end
          end
        end
        phaseExec: begin
          case (instrClass)
            clsAluReg, clsShiftVar, clsShiftImm: begin
              if (step == '0) begin
                regAWrite <= !immShift;   // Shift amount comes from the instruction
                regBWrite <= 1'b1;
              end
              if (step != '0 && step <= writeStep) begin
                if (!immShift) aluSrcA <= srcARegA;
                aluSrcB <= srcBRegB;
                aluOp <= aluFunc;
              end
              if (step == writeStep - 3'd1) aluOutWrite <= 1'b1;
              if (step == writeStep) begin
                regWrite <= 1'b1;
                regDst <= dstRd;
                regData <= dataAluOut;
              end
            end
            clsJumpReg: begin
              if (step == 3'd0) regAWrite <= 1'b1;
              if (step == 3'd1 || step == 3'd2) begin
                aluSrcA <= srcARegA;
                aluOp <= aluPassA;
              end
              if (step == 3'd2) begin
                pcSrc <= pcAluResult;   // Straight from the ALU
                pcWrite <= 1'b1;
              end
            end
            clsReturnExc: begin
              if (step == 3'd0) begin
                pcSrc <= pcEpc;
                pcWrite <= 1'b1;
              end
            end
            clsBreak: begin
              if (step == 3'd0) begin  // Undo the fetch increment
                aluSrcA <= srcAPc;
                aluSrcB <= srcBFour;
                aluOp <= aluSub;
                aluOutWrite <= 1'b1;
              end
              if (step == 3'd2) begin
                pcSrc <= pcAluOut;
                pcWrite <= 1'b1;
              end
            end
            default: ;   // mfhi, mflo and jal only wait for the write
          endcase
        end
        default: ;
      endcase
    end
  end

endmodule

// ==== hdl/controlUnit.sv ====
module controlUnit import ctrlPkg::*; #(
  parameter int MemLatency = 1
) (
  input logic clk,
  input logic reset_in,
  input opcode_t opcode,
  input funct_t funct,
  output logic resetOut,
  output logic pcWrite,
  output logic irWrite,
  output logic aluOutWrite,
  output logic regWrite,
  output logic regAWrite,
  output logic regBWrite,
  output pcSrc_t pcSrc,
  output aluSrcA_t aluSrcA,
  output aluSrcB_t aluSrcB,
  output regDst_t regDst,
  output regData_t regData,
  output aluOp_t aluOp
);

  logic decodeNow;
  instrClass_t instrClass;
  aluOp_t aluFunc;
  phase_t phase;
  step_t step;

  instrDecoder decoder (
    .clk(clk),
    .reset_in(reset_in),
    .opcode(opcode),
    .funct(funct),
    .decodeNow(decodeNow),
    .instrClass(instrClass),
    .aluFunc(aluFunc)
  );

  stepSequencer #(.MemLatency(MemLatency)) sequencer (
    .clk(clk),
    .reset_in(reset_in),
    .instrClass(instrClass),
    .phase(phase),
    .step(step),
    .decodeNow(decodeNow),
    .resetOut(resetOut)
  );

  controlEncoder #(.MemLatency(MemLatency)) encoder (
    .clk(clk),
    .reset_in(reset_in),
    .phase(phase),
    .step(step),
    .instrClass(instrClass),
    .aluFunc(aluFunc),
    .opcode(opcode),
    .funct(funct),
    .pcWrite(pcWrite),
    .irWrite(irWrite),
    .aluOutWrite(aluOutWrite),
    .regWrite(regWrite),
    .regAWrite(regAWrite),
    .regBWrite(regBWrite),
    .pcSrc(pcSrc),
    .aluSrcA(aluSrcA),
    .aluSrcB(aluSrcB),
    .regDst(regDst),
    .regData(regData),
    .aluOp(aluOp)
  );

endmodule

// ==== hdl/ctrlPkg.sv ====
package ctrlPkg;

  typedef logic [5:0] opcode_t;
  typedef logic [5:0] funct_t;
  typedef logic [2:0] step_t;

  localparam opcode_t opRType = 6'h00;
  localparam opcode_t opJ = 6'h02;
  localparam opcode_t opJal = 6'h03;

  // R-type funct codes
  localparam funct_t fnSll = 6'h00;
  localparam funct_t fnSrl = 6'h02;
  localparam funct_t fnSra = 6'h03;
  localparam funct_t fnSllv = 6'h04;
  localparam funct_t fnSrav = 6'h07;
  localparam funct_t fnJr = 6'h08;
  localparam funct_t fnBreak = 6'h0D;
  localparam funct_t fnMfhi = 6'h10;
  localparam funct_t fnMflo = 6'h12;
  localparam funct_t fnRte = 6'h13;
  localparam funct_t fnAdd = 6'h20;
  localparam funct_t fnSub = 6'h22;
  localparam funct_t fnAnd = 6'h24;
  localparam funct_t fnSlt = 6'h2A;

  typedef enum logic [3:0] {
    aluPassA = 4'd0,
    aluAdd = 4'd1,
    aluSub = 4'd2,
    aluAnd = 4'd3,
    aluPassB = 4'd4,   // Through the auxiliary ALU
    aluShiftL1 = 4'd5,
    aluShiftL2 = 4'd6,
    aluShiftR = 4'd7,
    aluShiftRa1 = 4'd8,
    aluShiftRa2 = 4'd9,
    aluSlti = 4'd10,
    aluBeq = 4'd11,
    aluBne = 4'd12,
    aluBle = 4'd13,
    aluBgt = 4'd14,
    aluLui = 4'd15
  } aluOp_t;

  typedef enum logic [3:0] {
    clsUnsupported,
    clsAluReg,
    clsShiftVar,
    clsShiftImm,
    clsJumpReg,
    clsMoveHiLo,
    clsReturnExc,
    clsBreak,
    clsJump,
    clsJumpLink
  } instrClass_t;

  typedef enum logic [1:0] {pcAluResult = 2'd0, pcAluOut = 2'd1, pcJumpTarget = 2'd2,
                            pcEpc = 2'd3} pcSrc_t;
  typedef enum logic [1:0] {srcAPc = 2'd0, srcARegA = 2'd1} aluSrcA_t;
  typedef enum logic [1:0] {srcBRegB = 2'd0, srcBFour = 2'd1} aluSrcB_t;
  typedef enum logic [1:0] {dstRt = 2'd0, dstRd = 2'd1, dstRa = 2'd3} regDst_t;
  typedef enum logic [2:0] {dataAluOut = 3'd0, dataHi = 3'd3, dataLo = 3'd4,
                            dataPc = 3'd6} regData_t;

  // Fetch first so a cold start counts as having left reset
  typedef enum logic [1:0] {phaseFetch = 2'd0, phaseExec = 2'd1, phaseReset = 2'd2} phase_t;

  // Execute cycles after fetch; 0 means straight back to fetch
  function automatic step_t execSteps(instrClass_t cls);
    case (cls)
      clsAluReg, clsShiftImm, clsJumpReg, clsBreak: return 3'd5;
      clsShiftVar: return 3'd6;   // Shifter needs an extra cycle
      clsMoveHiLo, clsReturnExc, clsJumpLink: return 3'd2;
      default: return 3'd0;
    endcase
  endfunction

endpackage

// ==== hdl/instrDecoder.sv ====
module instrDecoder import ctrlPkg::*; (
  input logic clk,
  input logic reset_in,
  input opcode_t opcode,
  input funct_t funct,
  input logic decodeNow,
  output instrClass_t instrClass,
  output aluOp_t aluFunc
);

  instrClass_t liveClass;
  instrClass_t heldClass;
  funct_t heldFunct;

  always_comb begin
    liveClass = clsUnsupported;
    if (opcode == opJ) liveClass = clsJump;
    else if (opcode == opJal) liveClass = clsJumpLink;
    else if (opcode == opRType) begin
      case (funct)
        fnAdd, fnAnd, fnSub, fnSlt: liveClass = clsAluReg;
        fnSrav, fnSllv: liveClass = clsShiftVar;
        fnSll, fnSra, fnSrl: liveClass = clsShiftImm;
        fnJr: liveClass = clsJumpReg;
        fnMfhi, fnMflo: liveClass = clsMoveHiLo;
        fnRte: liveClass = clsReturnExc;
        fnBreak: liveClass = clsBreak;
        default: liveClass = clsUnsupported;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (reset_in) heldClass <= clsUnsupported;
    else if (decodeNow) heldClass <= liveClass;
  end

  always_ff @(posedge clk) begin
    if (decodeNow) heldFunct <= funct;
  end

  // Sequencer needs the class during the decode step itself
  assign instrClass = decodeNow ? liveClass : heldClass;

  always_comb begin
    case (heldFunct)
      fnAdd: aluFunc = aluAdd;
      fnSub: aluFunc = aluSub;
      fnAnd: aluFunc = aluAnd;
      fnSlt: aluFunc = aluSlti;
      fnSrav: aluFunc = aluShiftRa2;
      fnSllv: aluFunc = aluShiftL2;
      fnSll: aluFunc = aluShiftL1;
      fnSra: aluFunc = aluShiftRa1;
      fnSrl: aluFunc = aluShiftR;
      default: aluFunc = aluPassA;
    endcase
  end

endmodule

// ==== hdl/stepSequencer.sv ====
module stepSequencer import ctrlPkg::*; #(
  parameter int MemLatency = 1
) (
  input logic clk,
  input logic reset_in,
  input instrClass_t instrClass,
  output phase_t phase,
  output step_t step,
  output logic decodeNow,
  output logic resetOut
);

  localparam step_t LastFetch = step_t'(MemLatency + 1);

  step_t nextStep;
  step_t execLen;

  assign nextStep = step + 3'd1;
  assign execLen = execSteps(instrClass);
  assign decodeNow = (phase == phaseFetch) && (step == LastFetch);

  always_ff @(posedge clk) begin
    if (reset_in) begin
      // High only on the edge that enters reset
      if (phase == phaseReset) resetOut <= 1'b0;
      else resetOut <= 1'b1;
      phase <= phaseReset;
      step <= '0;
    end else begin
      resetOut <= 1'b0;
      case (phase)
        phaseReset: begin
          phase <= phaseFetch;
          step <= '0;
        end
        phaseFetch: begin
          if (decodeNow) begin
            step <= '0;
            phase <= (execLen == '0) ? phaseFetch : phaseExec;  // j and unknown ops refetch
          end else begin
            step <= nextStep;
          end
        end
        phaseExec: begin
          if (nextStep == execLen) begin
            phase <= phaseFetch;
            step <= '0;
          end else begin
            step <= nextStep;
          end
        end
        default: begin
          phase <= phaseReset;
          step <= '0;
        end
      endcase
    end
  end

endmodule

// ==== sim/controlUnitTb.sv ====
module controlUnitTb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int MaxCases = 32;
  localparam int Fields = 7;
  localparam int WaitLimit = 20;

  logic clk;
  logic reset_in;
  logic [5:0] opcode;
  logic [5:0] funct;
  logic resetOut;
  logic pcWrite;
  logic irWrite;
  logic aluOutWrite;
  logic regWrite;
  logic regAWrite;
  logic regBWrite;
  logic [1:0] pcSrc;
  logic [1:0] aluSrcA;
  logic [1:0] aluSrcB;
  logic [1:0] regDst;
  logic [2:0] regData;
  logic [3:0] aluOp;

  logic [7:0] caseData [MaxCases * Fields];
  int caseCount;

  controlUnit #(.MemLatency(1)) DUT (
    .clk(clk),
    .reset_in(reset_in),
    .opcode(opcode),
    .funct(funct),
    .resetOut(resetOut),
    .pcWrite(pcWrite),
    .irWrite(irWrite),
    .aluOutWrite(aluOutWrite),
    .regWrite(regWrite),
    .regAWrite(regAWrite),
    .regBWrite(regBWrite),
    .pcSrc(pcSrc),
    .aluSrcA(aluSrcA),
    .aluSrcB(aluSrcB),
    .regDst(regDst),
    .regData(regData),
    .aluOp(aluOp)
  );

  always #20 clk = ~clk;

  task automatic reportFailure(input string what);
    $display("%s", what);
    $display("TB FAILED");
    $fatal(1);
  endtask

  task automatic compareValue(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
    if (got !== expected) begin
      reportFailure($sformatf("MISMATCH %s got 0x%0h expected 0x%0h", name, got, expected));
    end
  endtask

  // Every control output at its zero encoding
  task automatic checkIdle(input logic expReset);
    compareValue("resetOut", 32'(resetOut), 32'(expReset));
    compareValue("pcWrite", 32'(pcWrite), 32'd0);
    compareValue("irWrite", 32'(irWrite), 32'd0);
    compareValue("aluOutWrite", 32'(aluOutWrite), 32'd0);
    compareValue("regWrite", 32'(regWrite), 32'd0);
    compareValue("regAWrite", 32'(regAWrite), 32'd0);
    compareValue("regBWrite", 32'(regBWrite), 32'd0);
    compareValue("pcSrc", 32'(pcSrc), 32'd0);
    compareValue("aluSrcA", 32'(aluSrcA), 32'd0);
    compareValue("aluSrcB", 32'(aluSrcB), 32'd0);
    compareValue("regDst", 32'(regDst), 32'd0);
    compareValue("regData", 32'(regData), 32'd0);
    compareValue("aluOp", 32'(aluOp), 32'd0);
  endtask

  task automatic applyReset();
    reset_in = 1'b1;
    @(negedge clk);
    checkIdle(1'b1);   // resetOut pulses on the first reset edge only
    repeat (4) @(negedge clk);
    checkIdle(1'b0);
    reset_in = 1'b0;
  endtask

  task automatic waitForFetch();
    int waited;
    for (waited = 0; waited < WaitLimit && irWrite !== 1'b1; waited++) begin
      @(negedge clk);
    end
    if (irWrite !== 1'b1) begin
      reportFailure("irWrite did not appear within 20 cycles after reset was released");
    end
  endtask

  // Starts on the falling edge where irWrite is high, ends on the next one
  task automatic runCase(input int idx);
    int base;
    int cycles;
    logic regSeen;
    logic pcSeen;
    logic [3:0] seenAluOp;
    logic [1:0] seenDst;
    logic [2:0] seenData;
    logic [1:0] lastPcSrc;
    base = idx * Fields;
    opcode = caseData[base][5:0];
    funct = caseData[base + 1][5:0];
    $display("case %0d: opcode %02h funct %02h", idx, opcode, funct);
    cycles = 0;
    regSeen = 1'b0;
    pcSeen = 1'b0;
    seenAluOp = 4'd0;
    seenDst = 2'd0;
    seenData = 3'd0;
    lastPcSrc = 2'd0;
    do begin
      @(negedge clk);
      cycles++;
      if (regWrite === 1'b1 && !regSeen) begin
        regSeen = 1'b1;
        seenAluOp = aluOp;
        seenDst = regDst;
        seenData = regData;
      end
      if (pcWrite === 1'b1) begin  // Keep the last one
        pcSeen = 1'b1;
        lastPcSrc = pcSrc;
      end
    end while (irWrite !== 1'b1 && cycles < WaitLimit);
    if (irWrite !== 1'b1) begin
      reportFailure($sformatf("case %0d: the next irWrite did not come within 20 cycles", idx));
    end
    compareValue("irWrite period", 32'(cycles), 32'(caseData[base + 2]));
    if (caseData[base + 4] == 8'hFF) begin
      if (regSeen) reportFailure($sformatf("case %0d: register file written unexpectedly", idx));
    end else if (!regSeen) begin
      reportFailure($sformatf("case %0d: regWrite never came during the instruction", idx));
    end else begin
      compareValue("regDst", 32'(seenDst), 32'(caseData[base + 4]));
      compareValue("regData", 32'(seenData), 32'(caseData[base + 5]));
      if (caseData[base + 3] != 8'hFF) begin
        compareValue("aluOp", 32'(seenAluOp), 32'(caseData[base + 3]));
      end
    end
    if (!pcSeen) begin
      reportFailure($sformatf("case %0d: pcWrite never came during the instruction", idx));
    end else begin
      compareValue("pcSrc", 32'(lastPcSrc), 32'(caseData[base + 6]));
    end
  endtask

  initial begin
    clk = 1'b0;
    reset_in = 1'b1;
    opcode = 6'h3F;
    funct = 6'h3F;
    $readmemh("sim/instrCases.txt", caseData);
    caseCount = 0;
    while (caseCount < MaxCases && caseData[caseCount * Fields] != 8'hFF) begin
      caseCount++;
    end
    if (caseCount == 0 || caseCount == MaxCases) begin
      reportFailure("case file holds no cases or lacks its end marker");
    end

    applyReset();
    waitForFetch();
    for (int i = 0; i < caseCount; i++) begin
      runCase(i);
    end

    // Start an add and cut it off in execute
    opcode = caseData[0][5:0];
    funct = caseData[1][5:0];
    repeat (4) @(negedge clk);
    applyReset();
    waitForFetch();
    runCase(0);
    runCase(caseCount - 1);

    $display("TB PASSED");
    $finish;
  end

endmodule

// ==== sim/instrCases.txt ====
// opcode funct cycles aluOp regDst regData pcSrc
// FF is don't care; regDst FF means no register write; the FF line ends the table
00 20 08 01 01 00 01  // add
00 24 08 03 01 00 01  // and
00 22 08 02 01 00 01  // sub
00 2A 08 0A 01 00 01  // slt
00 07 09 09 01 00 01  // srav
00 04 09 06 01 00 01  // sllv
00 00 08 05 01 00 01  // sll
00 03 08 08 01 00 01  // sra
00 02 08 07 01 00 01  // srl
00 08 08 FF FF FF 00  // jr
00 10 05 FF 01 03 01  // mfhi
00 12 05 FF 01 04 01  // mflo
02 00 03 FF FF FF 02  // j
03 00 05 FF 03 06 02  // jal
00 13 05 FF FF FF 03  // rte
00 0D 08 FF FF FF 01  // break
08 00 03 FF FF FF 01  // addi, no execute states
00 18 03 FF FF FF 01  // mult, dropped
FF FF FF FF FF FF FF
